// File: verilog/mul_pkg.sv
package mul_pkg;

	localparam int word_w     = 64;                 // operand and product width
	localparam int slice_w    = 16;                 // bits of a consumed in one pass
	localparam int num_passes = word_w / slice_w;   // 4 passes per multiply
	localparam int acc_w      = word_w + slice_w;   // slice times full word

	typedef logic [word_w-1:0]              word_t;   // operands, product
	typedef logic [slice_w-1:0]             slice_t;  // one slice of a or of the result
	typedef logic [$clog2(num_passes)-1:0] pass_t;   // pass index 0..3
	typedef logic [acc_w-1:0]               acc_t;    // partial product, running sum

	// request payload, a is walked slice by slice, b is used whole
	typedef struct packed {
		word_t a;   // sliced operand
		word_t b;   // full-width operand
	} mul_operands_t;

	// sequencer states, one pass per clock between idle/done and done
	typedef enum logic [2:0] {
		idle  = 3'b000,   // nothing accepted since reset or flush
		pass0 = 3'b001,   // a[15:0]
		pass1 = 3'b010,   // a[31:16]
		pass2 = 3'b011,   // a[47:32]
		pass3 = 3'b100,   // a[63:48]
		done  = 3'b101    // result held until next request
	} mul_state_e;

	// fsm
	// idle -> pass0 -> pass1 -> pass2 -> pass3 -> done -> pass0 ...
	// flush from any state goes back to idle
	// the slice result of pass k lands in product[16k +: 16]

endpackage

// File: verilog/mul_control.sv
`timescale 1ns/1ps

module mul_control import mul_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  flush,        // pipeline restore, kills the op in flight
	input  logic  valid_in,     // one-cycle request strobe
	output logic  accept,       // operand stage captures on this edge
	output logic  busy,         // high in pass0..pass3
	output logic  first_pass,   // running sum starts from zero
	output pass_t pass,         // slice index for datapath
	output logic  valid_out     // completion level, held in done
);

	mul_state_e state;        // current sequencer state
	mul_state_e next_state;   // comb next state

	// requests only taken when nothing is running, flush wins
	assign accept = valid_in && !flush && ((state == idle) || (state == done));

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= idle;
		else if (flush)
			state <= idle;         // restore drops the operation
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;        // idle and done wait here
		case (state)
			idle,
			done: begin
				if (accept)
					next_state = pass0;   // back to back from done is fine
			end
			pass0: next_state = pass1;
			pass1: next_state = pass2;
			pass2: next_state = pass3;
			pass3: next_state = done;
			default: next_state = idle;  // unused encodings recover
		endcase
	end

	// pass index and busy decoded straight from state
	always_comb begin
		busy = 1'b1;
		pass = '0;
		case (state)
			pass0: pass = pass_t'(0);
			pass1: pass = pass_t'(1);
			pass2: pass = pass_t'(2);
			pass3: pass = pass_t'(3);
			default: busy = 1'b0;    // idle, done
		endcase
	end

	assign first_pass = (state == pass0);   // no prior sum yet
	assign valid_out  = (state == done);    // drops on next accept edge

endmodule

// File: verilog/mul_operand_stage.sv
`timescale 1ns/1ps

module mul_operand_stage import mul_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          flush,      // clears held operands
	input  logic          accept,     // load strobe from sequencer
	input  mul_operands_t operands,   // a and b from the request
	input  pass_t         pass,       // which slice of a to present
	output slice_t        a_slice,    // a[16*pass +: 16]
	output word_t         b_word      // held b, same every pass
);

	mul_operands_t           held;       // operands of the op in flight
	slice_t [num_passes-1:0] a_slices;   // held a viewed as four slices

	// capture only on accept, strobes during passes leave this alone
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			held <= '0;
		end else if (flush) begin
			held <= '0;              // restore zeroes the operands
		end else if (accept) begin
			held <= operands;
		end
	end

	assign a_slices = held.a;          // slice 0 is the low 16 bits

	// 4:1 slice mux, one slice per pass
	assign a_slice = a_slices[pass];
	assign b_word  = held.b;

endmodule

// File: verilog/mul_slice_accumulator.sv
`timescale 1ns/1ps

module mul_slice_accumulator import mul_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   flush,        // clears sum and product
	input  logic   busy,         // pass states, accumulate this clock
	input  logic   first_pass,   // ignore leftover sum
	input  pass_t  pass,         // result slice written this clock
	input  slice_t a_slice,      // current 16 bits of a
	input  word_t  b_word,       // full b
	output word_t  product       // low 64 bits of a*b
);

	acc_t                    partial;        // a_slice * b_word, 80 bits
	acc_t                    carry_in;       // upper part of previous sum
	acc_t                    sum_next;       // new running sum
	acc_t                    sum_q;          // registered running sum
	slice_t                  result_slice;   // finished 16 bits this pass
	slice_t [num_passes-1:0] product_q;      // result slices, slice 0 low

	// slice by word, never overflows 80 bits
	assign partial = acc_t'(a_slice) * acc_t'(b_word);

	// the low slice of the last sum is already final, so shift it out
	// and keep only what still has weight for the next slice
	assign carry_in = first_pass ? '0 : (sum_q >> slice_w);

	// partial + carry stays below 2^80
	assign sum_next = partial + carry_in;

	assign result_slice = sum_next[slice_w-1:0];   // bits 16*pass +: 16 of a*b

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sum_q <= '0;
		end else if (flush) begin
			sum_q <= '0;
		end else if (busy) begin
			sum_q <= sum_next;          // one pass per clock
		end
	end

	// each pass fills one slice, the rest keep their value
	// so product is complete right after the pass3 edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			product_q <= '0;
		end else if (flush) begin
			product_q <= '0;            // restore zeroes the result
		end else if (busy) begin
			product_q[pass] <= result_slice;
		end
	end

	// held unchanged in done and idle
	assign product = product_q;

endmodule

// File: verilog/multiplier.sv
`timescale 1ns/1ps

module multiplier import mul_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          flush,       // pipeline restore
	input  logic          valid_in,    // one-cycle request strobe
	input  mul_operands_t operands,    // a and b
	output word_t         product,     // low half of a*b, unsigned
	output logic          valid_out    // high four cycles after accept
);

	logic   accept;       // capture edge for operands
	logic   busy;         // pass0..pass3
	logic   first_pass;   // pass0 only
	pass_t  pass;         // slice index
	slice_t a_slice;      // selected slice of a
	word_t  b_word;       // held b

	mul_control i_mul_control (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.valid_in  (valid_in),
		.accept    (accept),
		.busy      (busy),
		.first_pass(first_pass),
		.pass      (pass),
		.valid_out (valid_out)
	);

	mul_operand_stage i_mul_operand_stage (
		.clk     (clk),
		.rst     (rst),
		.flush   (flush),
		.accept  (accept),
		.operands(operands),
		.pass    (pass),
		.a_slice (a_slice),
		.b_word  (b_word)
	);

	mul_slice_accumulator i_mul_slice_accumulator (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.busy      (busy),
		.first_pass(first_pass),
		.pass      (pass),
		.a_slice   (a_slice),
		.b_word    (b_word),
		.product   (product)
	);

endmodule

// File: dv/multiplier_assertions.sv
`timescale 1ns/1ps

module multiplier_assertions import mul_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  flush,       // pipeline restore
	input logic  accept,      // sequencer capture strobe
	input logic  busy,        // pass0..pass3
	input word_t b_word,      // held b from the operand stage
	input logic  valid_out    // completion level
);

	int fail_count = 0;   // read by the testbench at the end of the run

	// flush always lands in idle, so no completion right after it
	flush_clears_valid: assert property (
		@(posedge clk) disable iff (rst)
		flush |=> !valid_out
	) else begin
		fail_count++;
		$error("valid_out high in the cycle after flush");
	end

	// no completion while the four passes run
	no_early_valid: assert property (
		@(posedge clk) disable iff (rst)
		accept |=> (!valid_out)[*4]
	) else begin
		fail_count++;
		$error("valid_out high before the four passes finished");
	end

	// accepted op completes after pass3, unless flushed on the way
	valid_after_four: assert property (
		@(posedge clk) disable iff (rst)
		accept ##1 (!flush)[*4] |=> valid_out
	) else begin
		fail_count++;
		$error("valid_out missing four cycles after accept");
	end

	// an op in flight is never replaced
	operands_held_in_pass: assert property (
		@(posedge clk) disable iff (rst)
		busy && !flush |=> $stable(b_word)
	) else begin
		fail_count++;
		$error("held operands changed during a pass state");
	end

endmodule

bind multiplier multiplier_assertions i_multiplier_assertions (
	.clk      (clk),
	.rst      (rst),
	.flush    (flush),
	.accept   (accept),
	.busy     (busy),
	.b_word   (b_word),
	.valid_out(valid_out)
);

// File: dv/tb_multiplier.sv
`timescale 1ns/1ps

module tb_multiplier import mul_pkg::*; ();

	logic          clk = 1'b0;
	logic          rst;
	logic          flush;
	logic          valid_in;
	mul_operands_t operands;
	word_t         product;
	logic          valid_out;

	logic [31:0] lcg_state = 32'h407d_07bc;   // fixed seed
	int          cycle_cnt = 0;               // rising edges since start
	int          accept_cycle;                // cycle_cnt seen after the accepting edge
	int          num_done = 0;                // ops that completed in the stimulus
	int          checked = 0;                 // results compared by the checker
	logic        valid_out_q = 1'b0;          // valid_out at the previous falling edge
	word_t       last_exp;                    // expected result of the latest op
	word_t       exp_q[$];                    // expected products, oldest first

	multiplier i_multiplier (
		.clk      (clk),
		.rst      (rst),
		.flush    (flush),
		.valid_in (valid_in),
		.operands (operands),
		.product  (product),
		.valid_out(valid_out)
	);

	always #50 clk = ~clk;   // 100 ns period

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// numerical recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi, lo};
	endfunction

	// low half of the full unsigned product
	function automatic word_t ref_product(input word_t a, input word_t b);
		logic [2*word_w-1:0] full;
		full = {{word_w{1'b0}}, a} * {{word_w{1'b0}}, b};
		return full[word_w-1:0];
	endfunction

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
			abort_run("word compare failed");
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
			abort_run("bit compare failed");
		end
	endtask

	// strobe one request, returns after the accepting edge
	task automatic issue(input word_t a, input word_t b);
		@(posedge clk);
		valid_in   <= 1'b1;
		operands.a <= a;
		operands.b <= b;
		last_exp = ref_product(a, b);
		exp_q.push_back(last_exp);
		@(posedge clk);                    // accepting edge
		valid_in <= 1'b0;
		@(negedge clk);
		accept_cycle = cycle_cnt;
		check_bit("valid_out", valid_out, 1'b0);   // old result dropped
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		while (!valid_out) begin
			if (waited == 20) begin
				abort_run("timeout, valid_out did not rise within 20 cycles of accept");
			end else begin
				@(negedge clk);
				waited++;
			end
		end
		if (cycle_cnt - accept_cycle != num_passes)
			abort_run($sformatf("valid_out rose %0d cycles after accept instead of 4",
				cycle_cnt - accept_cycle));
	endtask

	task automatic run_op(input word_t a, input word_t b);
		issue(a, b);
		wait_done();
		num_done++;
	endtask

	// compares every completion against the oldest expected value
	always @(negedge clk) begin
		if (!rst && valid_out && !valid_out_q) begin
			if (exp_q.size() == 0)
				abort_run("valid_out rose with no request outstanding");
			else begin
				check_word("product", product, exp_q.pop_front());
				checked++;
			end
		end
		valid_out_q = valid_out;
	end

	initial begin
		word_t a;
		word_t b;
		int    i;
		rst      = 1'b1;
		flush    = 1'b0;
		valid_in = 1'b0;
		operands = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("valid_out", valid_out, 1'b0);
		check_word("product", product, '0);

		run_op(64'h0, 64'h1234_5678_9abc_def0);   // zero times a value
		run_op(64'h1, '1);                        // one times all ones
		run_op('1, '1);                           // all ones squared
		run_op(64'h0000_0100_0000_0000, 64'h0fed_cba9_8765_4321);   // power of two
		run_op(64'hffff_0000_0000_0000, 64'h0000_0000_abcd_ef01);   // high bits only

		// next request right after each completion
		for (i = 0; i < 200; i++) begin
			a = rand_word();
			b = rand_word();
			run_op(a, b);
		end

		// result holds in done
		for (i = 0; i < 6; i++) begin
			@(negedge clk);
			check_bit("valid_out", valid_out, 1'b1);
			check_word("product", product, last_exp);
		end

		// strobes during pass1/pass2 must not be taken
		a = rand_word();
		b = rand_word();
		issue(a, b);
		@(posedge clk);
		valid_in   <= 1'b1;
		operands.a <= rand_word();
		operands.b <= rand_word();
		@(posedge clk);
		@(posedge clk);
		valid_in <= 1'b0;
		wait_done();
		num_done++;

		// flush in pass3, the state would reach done without it
		issue(rand_word(), rand_word());
		@(posedge clk);
		@(posedge clk);
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);                    // flush edge
		flush <= 1'b0;
		@(negedge clk);
		check_bit("valid_out", valid_out, 1'b0);
		check_word("product", product, '0);
		exp_q.delete();                    // flushed op never completes
		for (i = 0; i < 5; i++) begin
			@(negedge clk);
			check_bit("valid_out", valid_out, 1'b0);
		end
		run_op(rand_word(), rand_word());

		@(negedge clk);
		if (checked != num_done || exp_q.size() != 0 ||
			i_multiplier.i_multiplier_assertions.fail_count != 0) begin
			abort_run("missed completions or assertion failures");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: verilog.f
verilog/mul_pkg.sv
verilog/mul_control.sv
verilog/mul_operand_stage.sv
verilog/mul_slice_accumulator.sv
verilog/multiplier.sv
dv/multiplier_assertions.sv
dv/tb_multiplier.sv
